/* sources.f */
+incdir+hdl
hdl/spinnlink_pkg.sv
hdl/nrz_2of7_decoder.sv
hdl/packet_framer.sv
hdl/packet_out_reg.sv
hdl/spinnlink_receiver.sv
tb/link_clock_gen.sv
tb/tb_spinnlink_receiver.sv

/* tb/link_tests.txt */
# kind payload stall, payload in hex with nibble 0 as the lowest digit
# stall above 0 parks that packet and holds the next packet's eop for stall cycles
short     9876543210          0
long      123456789abcdef013  0
early-eop abcdef01            0
short     13579bdf0c          0
oob       5a5a5a5a5a          0
long      ffeeddccbbaa998877  0
split     2468ace135          0
split     a5a5a5a5a4          0
short     0123456789          8
long      11223344556677889a  0
short     fedcba9870          0
long      0f1e2d3c4b5a697887  0

/* tb/tb_spinnlink_receiver.sv */
// spinnaker link receiver testbench
`timescale 1ns/100ps
`include "spinnlink_consts.svh"

module tb_spinnlink_receiver;

  localparam int ack_timeout = 50;                         // cycles per symbol
  localparam logic [`SL_WIRES-1:0] oob_code = 7'b0000111;  // three wires at once
  localparam logic [16*`SL_WIRES-1:0] code_table = {`SL_CODE_15, `SL_CODE_14, `SL_CODE_13,
    `SL_CODE_12, `SL_CODE_11, `SL_CODE_10, `SL_CODE_9, `SL_CODE_8, `SL_CODE_7, `SL_CODE_6,
    `SL_CODE_5, `SL_CODE_4, `SL_CODE_3, `SL_CODE_2, `SL_CODE_1, `SL_CODE_0};  // nibble 0 lowest

  logic                    CLK_IN;
  logic                    RESET_IN;
  logic [`SL_WIRES-1:0]    link_wires;  // sender copy of the wires
  logic                    SL_ACK_OUT;
  logic [`SL_PKT_BITS-1:0] PKT_DATA_OUT;
  logic                    PKT_VLD_OUT;
  logic                    PKT_RDY_IN;
  logic [`SL_PKT_BITS-1:0] exp_q [$];   // packets due out in order
  logic [`SL_PKT_BITS-1:0] want_pkt;
  logic [`SL_PKT_BITS-1:0] payload;
  logic                    hold_low;    // ready forced low
  bit                      aborted;     // a wait ran out
  string                   kind;
  int                      stall;
  int                      hold_next;   // eop hold for the following packet
  int                      i;
  int                      errors;
  int                      aborts;
  integer                  fd;
  integer                  seed;
  integer                  rdy_seed;

  link_clock_gen u_clk (.CLK_IN(CLK_IN), .RESET_IN(RESET_IN));

  spinnlink_receiver uut
  (
    .CLK_IN          (CLK_IN),
    .RESET_IN        (RESET_IN),
    .SL_DATA_2OF7_IN (link_wires),
    .SL_ACK_OUT      (SL_ACK_OUT),
    .PKT_DATA_OUT    (PKT_DATA_OUT),
    .PKT_VLD_OUT     (PKT_VLD_OUT),
    .PKT_RDY_IN      (PKT_RDY_IN)
  );

  task automatic log_mismatch(input string name, input logic [`SL_PKT_BITS-1:0] expected,
                              input logic [`SL_PKT_BITS-1:0] actual);
    $display("CHECK FAILED time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("run stopped at %0t, %s", $time, what);
    aborts++;
    aborted = 1'b1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 8 * ack_timeout)
    begin
      @(negedge CLK_IN);
      waited++;
    end
    if (exp_q.size() != 0)
      abort_run("expected packets never left the output port");
  endtask

  // send one symbol whole or one wire first and wait for its ack toggle
  task automatic send_symbol(input logic [`SL_WIRES-1:0] code, input bit split,
                             input int hold_cycles);
    logic                 prev_ack;
    logic [`SL_WIRES-1:0] first_step;
    int                   n;
    if (!aborted)
    begin
      prev_ack   = SL_ACK_OUT;
      first_step = split ? (code & (~code + 1'b1)) : code;  // lowest wire alone
      link_wires = link_wires ^ first_step;
      for (n = 0; n < (split ? 5 : hold_cycles); n++)
      begin
        @(negedge CLK_IN);
        if (SL_ACK_OUT !== prev_ack)
          log_mismatch("SL_ACK_OUT", prev_ack, SL_ACK_OUT);  // nothing complete yet
        if (hold_cycles > 0 && PKT_VLD_OUT !== 1'b1)
          log_mismatch("PKT_VLD_OUT", 1, PKT_VLD_OUT);       // parked packet stays
        if (hold_cycles > 0 && PKT_DATA_OUT !== exp_q[0])
          log_mismatch("PKT_DATA_OUT", exp_q[0], PKT_DATA_OUT);
      end
      link_wires = link_wires ^ (code ^ first_step);  // second wire of a split
      if (hold_cycles > 0)
        hold_low <= 1'b0;  // let the parked packet go
      n = 0;
      while (SL_ACK_OUT === prev_ack && n < ack_timeout)
      begin
        @(negedge CLK_IN);
        n++;
      end
      if (SL_ACK_OUT === prev_ack)
        abort_run("link ack never toggled");
    end
  endtask

  // --------------------------------------------------------------------------
  // ready driver and packet checker
  // --------------------------------------------------------------------------
  always @(negedge CLK_IN)
    PKT_RDY_IN = !hold_low && !RESET_IN && (($random(rdy_seed) & 3) != 0);  // low 1 in 4

  always @(posedge CLK_IN)
  begin
    if (!RESET_IN && PKT_VLD_OUT && PKT_RDY_IN)
    begin
      if (exp_q.size() == 0)
      begin
        $display("unexpected packet transfer at %0t, data %h", $time, PKT_DATA_OUT);
        errors++;
      end
      else
      begin
        want_pkt = exp_q.pop_front();
        if (PKT_DATA_OUT !== want_pkt)
          log_mismatch("PKT_DATA_OUT", want_pkt, PKT_DATA_OUT);
      end
    end
  end

  initial
  begin
    link_wires = '0;
    PKT_RDY_IN = 1'b0;
    hold_low   = 1'b0;
    hold_next  = 0;
    aborted    = 1'b0;
    errors     = 0;
    aborts     = 0;
    seed       = 21;
    rdy_seed   = seed;
    @(negedge CLK_IN);
    if (SL_ACK_OUT !== 1'b0)
      log_mismatch("SL_ACK_OUT", 0, SL_ACK_OUT);
    if (PKT_VLD_OUT !== 1'b0)
      log_mismatch("PKT_VLD_OUT", 0, PKT_VLD_OUT);
    i = 0;
    while (RESET_IN !== 1'b0 && i < ack_timeout)
    begin
      @(posedge CLK_IN);  // reset drops between two rising edges
      i++;
    end
    if (RESET_IN !== 1'b0)
      abort_run("reset never dropped");
    @(negedge CLK_IN);
    if (SL_ACK_OUT !== 1'b1)
      log_mismatch("SL_ACK_OUT", 1, SL_ACK_OUT);  // first edge after reset raises the ack
    fd = $fopen("tb/link_tests.txt", "r");
    if (fd == 0)
      abort_run("cannot open tb/link_tests.txt");
    while (!aborted && $fscanf(fd, "%s", kind) == 1)
    begin
      if (kind == "#")
      begin
        i = $fgetc(fd);  // skip the rest of a comment line
        while (i != 10 && i != -1)
          i = $fgetc(fd);
      end
      else if ($fscanf(fd, "%h %d", payload, stall) != 2)
        abort_run("malformed line in the vector file");
      else
      begin
        if (kind == "oob")
          send_symbol(oob_code, 1'b0, 0);
        if (stall > 0)
        begin
          wait_drain();
          hold_low <= 1'b1;  // this packet parks in the output register
        end
        for (i = 0; i < ((kind == "long") ? `SL_LONG_SYMS :
                         (kind == "early-eop") ? 6 : `SL_SHORT_SYMS); i++)
          send_symbol(code_table[payload[4*i +: 4] * `SL_WIRES +: `SL_WIRES],
                      kind == "split" || ($random(seed) & 7) == 0, 0);
        if (kind == "long")
          exp_q.push_back(payload);
        else if (kind == "short" || kind == "split")
          exp_q.push_back({{(`SL_PKT_BITS-`SL_SHORT_BITS){1'b0}}, payload[`SL_SHORT_BITS-1:0]});
        send_symbol(`SL_EOP_CODE, kind == "split" && hold_next == 0, hold_next);
        hold_next = stall;
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (!aborted)
      wait_drain();
    repeat (20) @(negedge CLK_IN);  // room for a stray transfer
    if (PKT_VLD_OUT !== 1'b0)
      log_mismatch("PKT_VLD_OUT", 0, PKT_VLD_OUT);
    $display("errors: %0d check failures, %0d aborts", errors, aborts);
    if (errors == 0 && aborts == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* tb/link_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/100ps

module link_clock_gen
(
  output logic CLK_IN,
  output logic RESET_IN
);

  localparam int half_period = 50;  // 100 ns clock

  initial
  begin
    CLK_IN = 1'b0;
    forever #half_period CLK_IN = ~CLK_IN;
  end

  // reset over 4 rising edges, dropped on a falling edge
  initial
  begin
    RESET_IN = 1'b1;
    repeat (4) @(posedge CLK_IN);
    @(negedge CLK_IN);
    RESET_IN = 1'b0;
  end

endmodule

/* hdl/spinnlink_receiver.sv */
// spinnaker link receiver top
`timescale 1ns/100ps
`include "spinnlink_consts.svh"

module spinnlink_receiver
  import spinnlink_pkg::*;
(
  input  logic                    CLK_IN,
  input  logic                    RESET_IN,
  input  logic [`SL_WIRES-1:0]    SL_DATA_2OF7_IN,  // nrz 2-of-7 link
  output logic                    SL_ACK_OUT,
  output logic [`SL_PKT_BITS-1:0] PKT_DATA_OUT,     // valid/ready packet port
  output logic                    PKT_VLD_OUT,
  input  logic                    PKT_RDY_IN
);

  sym_class_t                 sym_class;
  logic [`SL_NIBBLE_BITS-1:0] sym_nibble;
  logic                       sym_accept;
  logic                       pkt_strobe;
  logic [`SL_PKT_BITS-1:0]    pkt_data;
  logic                       busy;

  // --------------------------------------------------------------------------
  // decoder -> framer -> output register
  // --------------------------------------------------------------------------
  nrz_2of7_decoder u_decoder
  (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .sl_data    (SL_DATA_2OF7_IN),
    .sym_accept (sym_accept),
    .sym_class  (sym_class),
    .sym_nibble (sym_nibble),
    .sl_ack     (SL_ACK_OUT)
  );

  packet_framer u_framer
  (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .sym_class  (sym_class),
    .sym_nibble (sym_nibble),
    .busy       (busy),
    .sym_accept (sym_accept),
    .pkt_strobe (pkt_strobe),
    .pkt_data   (pkt_data)
  );

  packet_out_reg u_out_reg
  (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .pkt_strobe   (pkt_strobe),
    .pkt_data     (pkt_data),
    .busy         (busy),
    .pkt_data_out (PKT_DATA_OUT),
    .pkt_vld      (PKT_VLD_OUT),
    .pkt_rdy      (PKT_RDY_IN)
  );

endmodule

/* hdl/packet_out_reg.sv */
// packet output register
`timescale 1ns/100ps
`include "spinnlink_consts.svh"

module packet_out_reg
(
  input  logic                    CLK_IN,
  input  logic                    RESET_IN,
  input  logic                    pkt_strobe,   // new packet from framer
  input  logic [`SL_PKT_BITS-1:0] pkt_data,
  output logic                    busy,         // full and not draining
  output logic [`SL_PKT_BITS-1:0] pkt_data_out,
  output logic                    pkt_vld,
  input  logic                    pkt_rdy
);

  logic full;  // one packet held

  // --------------------------------------------------------------------------
  // payload, loaded only on a framer strobe
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN)
  begin
    if (pkt_strobe)
      pkt_data_out <= pkt_data;
  end

  // strobe wins over a transfer on the same edge
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      full <= 1'b0;
    else if (pkt_strobe)
      full <= 1'b1;
    else if (pkt_rdy)
      full <= 1'b0;  // transfer done or already empty
  end

  assign pkt_vld = full;
  assign busy    = full && !pkt_rdy;  // ready frees the slot this edge

endmodule

/* hdl/packet_framer.sv */
// spinnaker packet framer
`timescale 1ns/100ps
`include "spinnlink_consts.svh"

module packet_framer
  import spinnlink_pkg::*;
(
  input  logic                       CLK_IN,
  input  logic                       RESET_IN,
  input  sym_class_t                 sym_class,
  input  logic [`SL_NIBBLE_BITS-1:0] sym_nibble,
  input  logic                       busy,        // output register can't take a packet
  output logic                       sym_accept,  // ack current symbol
  output logic                       pkt_strobe,  // packet complete
  output logic [`SL_PKT_BITS-1:0]    pkt_data
);

  frame_state_t                state;
  frame_state_t                state_nxt;
  logic [`SL_CNT_BITS-1:0]     sym_cnt;   // data symbols so far
  logic                        long_pkt;  // from first nibble
  logic                        exp_eop;   // count matches length
  logic                        is_data;
  logic                        is_eop;
  logic                        is_oob;
  logic [`SL_PKT_BITS-1:0]     pkt_buf;   // nibble shift buffer

  assign is_data = (sym_class == sym_data);
  assign is_eop  = (sym_class == sym_eop);
  assign is_oob  = (sym_class == sym_oob);

  assign exp_eop = long_pkt ? (sym_cnt == `SL_CNT_BITS'(`SL_LONG_SYMS))
                            : (sym_cnt == `SL_CNT_BITS'(`SL_SHORT_SYMS));

  // only a well timed eop waits on the output register
  assign pkt_strobe = (state == st_tran) && is_eop && exp_eop && !busy;

  // --------------------------------------------------------------------------
  // symbol accept and next state
  // --------------------------------------------------------------------------
  always_comb
  begin
    sym_accept = 1'b0;
    state_nxt  = state;
    case (state)
      st_rest:
      begin
        sym_accept = 1'b1;  // first ack after reset, unconditional
        state_nxt  = st_idle;
      end
      st_idle:
      begin
        sym_accept = (sym_class != sym_none);
        if (is_data)
          state_nxt = st_tran;  // frame starts
        else if (is_oob)
          state_nxt = st_err;
      end
      st_tran:
      begin
        if (is_data)
          sym_accept = 1'b1;
        else if (is_oob)
        begin
          sym_accept = 1'b1;
          state_nxt  = st_err;
        end
        else if (is_eop && !exp_eop)
        begin
          sym_accept = 1'b1;  // bad length, frame dropped
          state_nxt  = st_idle;
        end
        else if (pkt_strobe)
        begin
          sym_accept = 1'b1;
          state_nxt  = st_idle;
        end
      end
      st_err:
      begin
        sym_accept = (sym_class != sym_none);  // swallow until eop
        if (is_eop)
          state_nxt = st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      state <= st_rest;
    else
      state <= state_nxt;
  end

  // --------------------------------------------------------------------------
  // symbol count and length flag
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      sym_cnt  <= '0;
      long_pkt <= 1'b0;
    end
    else if (state == st_idle)
    begin
      sym_cnt <= is_data ? `SL_CNT_BITS'(1) : '0;
      if (is_data)
        long_pkt <= sym_nibble[`SL_LEN_BIT];  // length from header nibble
    end
    else if (state == st_tran)
    begin
      if (is_data)
        sym_cnt <= sym_cnt + 1'b1;
    end
    else
      sym_cnt <= '0;  // rest and error restart the count
  end

  // --------------------------------------------------------------------------
  // shift buffer, first nibble ends up at the bottom
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN)
  begin
    if (is_data && (state == st_idle || state == st_tran))
      pkt_buf <= {sym_nibble, pkt_buf[`SL_PKT_BITS-1:`SL_NIBBLE_BITS]};
  end

  // short packet sits in the top 40 bits
  assign pkt_data = long_pkt ? pkt_buf
                  : {{(`SL_PKT_BITS-`SL_SHORT_BITS){1'b0}},
                     pkt_buf[`SL_PKT_BITS-1 -: `SL_SHORT_BITS]};

endmodule

/* hdl/nrz_2of7_decoder.sv */
// nrz 2-of-7 symbol decoder
`timescale 1ns/100ps
`include "spinnlink_consts.svh"

module nrz_2of7_decoder
  import spinnlink_pkg::*;
(
  input  logic                       CLK_IN,
  input  logic                       RESET_IN,
  input  logic [`SL_WIRES-1:0]       sl_data,     // raw link wires
  input  logic                       sym_accept,  // strobe from framer
  output sym_class_t                 sym_class,
  output logic [`SL_NIBBLE_BITS-1:0] sym_nibble,
  output logic                       sl_ack
);

  logic [`SL_WIRES-1:0] last_wires;  // wire state at last ack
  logic [`SL_WIRES-1:0] diff;        // wires changed since then

  assign diff = sl_data ^ last_wires;

  // --------------------------------------------------------------------------
  // transition classification
  // --------------------------------------------------------------------------
  always_comb
  begin
    sym_nibble = '0;        // non-data gives nibble 0
    sym_class  = sym_data;  // overridden below for non-data
    case (diff)
      `SL_CODE_0:   sym_nibble = 4'd0;
      `SL_CODE_1:   sym_nibble = 4'd1;
      `SL_CODE_2:   sym_nibble = 4'd2;
      `SL_CODE_3:   sym_nibble = 4'd3;
      `SL_CODE_4:   sym_nibble = 4'd4;
      `SL_CODE_5:   sym_nibble = 4'd5;
      `SL_CODE_6:   sym_nibble = 4'd6;
      `SL_CODE_7:   sym_nibble = 4'd7;
      `SL_CODE_8:   sym_nibble = 4'd8;
      `SL_CODE_9:   sym_nibble = 4'd9;
      `SL_CODE_10:  sym_nibble = 4'd10;
      `SL_CODE_11:  sym_nibble = 4'd11;
      `SL_CODE_12:  sym_nibble = 4'd12;
      `SL_CODE_13:  sym_nibble = 4'd13;
      `SL_CODE_14:  sym_nibble = 4'd14;
      `SL_CODE_15:  sym_nibble = 4'd15;
      `SL_EOP_CODE: sym_class  = sym_eop;
      default:
      begin
        // a single wire flip is half a symbol, keep waiting
        if ($countones(diff) < 2)
          sym_class = sym_none;
        else
          sym_class = sym_oob;  // 3+ wires or bad pair
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // wire memory and link ack
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      last_wires <= '0;
      sl_ack     <= 1'b0;
    end
    else if (sym_accept)
    begin
      last_wires <= sl_data;  // new reference for next symbol
      sl_ack     <= ~sl_ack;  // tell sender to move on
    end
  end

endmodule

/* hdl/spinnlink_pkg.sv */
// spinnaker link receiver types
package spinnlink_pkg;

  // ------------------------------------------------------------------------
  // symbol class of the current wire transition
  // ------------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    sym_none = 2'd0,  // zero or one wire changed
    sym_data = 2'd1,  // one of the 16 nibble codes
    sym_eop  = 2'd2,  // end of packet
    sym_oob  = 2'd3   // anything else
  } sym_class_t;

  // ------------------------------------------------------------------------
  // framer state
  // ------------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    st_rest = 2'd0,  // first cycle after reset
    st_idle = 2'd1,  // between packets
    st_tran = 2'd2,  // collecting nibbles
    st_err  = 2'd3   // waiting for eop to resync
  } frame_state_t;

endpackage

/* hdl/spinnlink_consts.svh */
// spinnaker link receiver constants
`ifndef SPINNLINK_CONSTS_SVH
`define SPINNLINK_CONSTS_SVH

`define SL_PKT_BITS     72   // widest packet, long form
`define SL_SHORT_BITS   40   // short packet payload
`define SL_NIBBLE_BITS  4    // one symbol carries a nibble
`define SL_WIRES        7    // 2-of-7 data wires
`define SL_SHORT_SYMS   10
`define SL_LONG_SYMS    18
`define SL_CNT_BITS     5    // enough for 18 symbols
`define SL_LEN_BIT      1    // length flag in first nibble
`define SL_EOP_CODE     7'b1100000

// nrz 2-of-7 transition patterns, one per nibble value
`define SL_CODE_0       7'b0010001
`define SL_CODE_1       7'b0010010
`define SL_CODE_2       7'b0010100
`define SL_CODE_3       7'b0011000
`define SL_CODE_4       7'b0100001
`define SL_CODE_5       7'b0100010
`define SL_CODE_6       7'b0100100
`define SL_CODE_7       7'b0101000
`define SL_CODE_8       7'b1000001
`define SL_CODE_9       7'b1000010
`define SL_CODE_10      7'b1000100
`define SL_CODE_11      7'b1001000
`define SL_CODE_12      7'b0000011
`define SL_CODE_13      7'b0000110
`define SL_CODE_14      7'b0001100
`define SL_CODE_15      7'b0001001

`endif
